/* bench/burst_checker.sv */
`timescale 1ns/1ns

module burst_checker
    import axis_pkg::*;
    import burst_pkg::*;
(
    input  logic                   axis_clk,
    input  logic                   axis_reset,

    // input side, source of the payload and back-pressure
    input  axis_word_t             in_data,
    input  axis_keep_t             in_keep,
    input  logic                   in_last,
    input  logic                   in_user,
    input  logic                   in_valid,
    input  logic                   in_ready,

    // current table row and configuration
    input  logic [count_width-1:0] preamble_words,
    input  axis_word_t             preamble_pattern,
    input  axis_word_t             trailer_pattern,
    input  int                     test_idx,
    input  int                     test_len,
    input  logic                   test_expect,
    input  logic                   test_start,

    // lane side
    input  axis_word_t             out_data,
    input  axis_keep_t             out_keep,
    input  logic                   out_last,
    input  logic                   out_user,
    input  logic                   out_valid,

    output logic                   test_done,
    output int                     error_count,
    output int                     pass_count,
    output int                     fail_count
);

    localparam int idle_span = 20;  // cycles watched on a row with no frame

    logic [37:0] expect_q [$];  // {user, last, keep, data} per lane word
    logic [37:0] exp_word;
    int          test_errs;
    int          idle_cycles;
    logic        saw_full;      // in_ready dropped with a word waiting
    logic        active;

    // keep rule, bytes without a keep flag read as zero
    function automatic axis_word_t kept_bytes(axis_word_t w, axis_keep_t k);
        return w & {{8{k[3]}}, {8{k[2]}}, {8{k[1]}}, {8{k[0]}}};
    endfunction

    task automatic compare_field(string name, logic [31:0] exp, logic [31:0] got);
        if (exp !== got) begin
            $display("[ERROR] test %0d %s expected %h got %h", test_idx, name, exp, got);
            test_errs++;
            error_count++;
        end
    endtask

    task automatic report_problem(string what);
        $display("test %0d: %s", test_idx, what);
        test_errs++;
        error_count++;
    endtask

    task automatic finish_test();
        if (test_len > buffer_depth && !saw_full)
            report_problem("in_ready never dropped although the frame overfills the buffer");
        if (expect_q.size() != 0)
            report_problem("burst ended with expected words still unseen");
        if (test_errs == 0) begin
            $display("test %0d done: frame of %0d words ok", test_idx, test_len);
            pass_count++;
        end else begin
            $display("test %0d done: %0d errors", test_idx, test_errs);
            fail_count++;
        end
        active    = 1'b0;
        test_done = 1'b1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // sampled on the falling edge, away from every driving edge
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge axis_clk) begin
        if (axis_reset) begin
            expect_q.delete();
            test_done   = 1'b0;
            active      = 1'b0;
            error_count = 0;
            pass_count  = 0;
            fail_count  = 0;
            test_errs   = 0;
        end else begin
            if (test_start) begin
                expect_q.delete();
                test_errs   = 0;
                idle_cycles = 0;
                saw_full    = 1'b0;
                active      = 1'b1;
                test_done   = 1'b0;
                if (test_expect) begin
                    for (int i = 0; i < preamble_words; i++)
                        expect_q.push_back({2'b00, keep_all, preamble_pattern});
                    expect_q.push_back({2'b00, keep_all, delimiter_word});
                end
            end

            // payload enters the expected burst as it is accepted
            if (in_valid && in_ready) begin
                if (in_last) begin
                    expect_q.push_back({in_user, 1'b0, in_keep, kept_bytes(in_data, in_keep)});
                    for (int i = 0; i < trailer_repeat; i++)
                        expect_q.push_back({1'b0, i == trailer_repeat - 1, keep_all,
                                            trailer_pattern});
                end else begin
                    expect_q.push_back({in_user, 1'b0, in_keep, in_data});
                end
            end
            if (in_valid && !in_ready)
                saw_full = 1'b1;

            if (out_valid) begin
                if (expect_q.size() == 0) begin
                    report_problem("lane carried a word while no burst was expected");
                end else begin
                    exp_word = expect_q.pop_front();
                    compare_field("out_data", exp_word[31:0], out_data);
                    compare_field("out_keep", exp_word[35:32], out_keep);
                    compare_field("out_last", exp_word[36], out_last);
                    compare_field("out_user", exp_word[37], out_user);
                    if (exp_word[36] && active)
                        finish_test();  // last trailer closes the row
                end
            end

            // row without a frame, lane idle and buffer open
            if (active && !test_expect) begin
                if (!in_ready)
                    report_problem("in_ready low with an empty buffer");
                idle_cycles++;
                if (idle_cycles == idle_span)
                    finish_test();
            end
        end
    end

endmodule

/* bench/burst_properties.sv */
`timescale 1ns/1ns

module burst_properties
    import burst_pkg::*;
(
    input logic axis_clk,
    input logic axis_reset,
    input logic out_valid,
    input logic out_last,
    input logic pop
);

    int                     assert_failures = 0;  // read by the testbench at the end
    logic [count_width-1:0] gap_left;             // idle cycles still owed after out_last

    always_ff @(posedge axis_clk) begin
        if (axis_reset)
            gap_left <= '0;
        else if (out_last)
            gap_left <= ifg_words;  // gap starts on the next cycle
        else if (gap_left != '0)
            gap_left <= gap_left - 16'd1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // sequencer output rules
    ////////////////////////////////////////////////////////////////////////////

    last_needs_valid: assert property (
        @(posedge axis_clk) disable iff (axis_reset) out_last |-> out_valid)
        else begin
            $error("out_last raised while out_valid is low");
            assert_failures++;
        end

    // lane stays quiet for the whole inter-frame gap
    quiet_gap: assert property (
        @(posedge axis_clk) disable iff (axis_reset) (gap_left != '0) |-> !out_valid)
        else begin
            $error("out_valid high inside the inter-frame gap");
            assert_failures++;
        end

    // popped head word lands on the lane one cycle later
    pop_reaches_lane: assert property (
        @(posedge axis_clk) disable iff (axis_reset) pop |=> out_valid)
        else begin
            $error("popped word missing from the lane on the next cycle");
            assert_failures++;
        end

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock #(
    parameter int period_ns = 40
) (
    output logic axis_clk,
    output logic axis_reset
);

    initial begin
        axis_clk = 1'b0;
        forever #(period_ns / 2) axis_clk = ~axis_clk;  // free running
    end

    // reset held over the first two rising edges
    initial begin
        axis_reset = 1'b1;
        repeat (2) @(posedge axis_clk);
        #2 axis_reset = 1'b0;  // released just after the edge
    end

endmodule

/* bench/tb_top.sv */
`timescale 1ns/1ns

module tb_top
    import axis_pkg::*;
    import burst_pkg::*;
;

    localparam int clk_period = 40;
    localparam int num_tests  = 9;

    ////////////////////////////////////////////////////////////////////////////
    // stimulus table, one row per test
    ////////////////////////////////////////////////////////////////////////////

    // rows: idle, full, short, keep 1, keep 3, keep 7, pre 12, pre 1, overfill
    localparam int         len_tab    [num_tests] = '{0, 20, 3, 5, 12, 7, 9, 16, 80};
    localparam axis_keep_t keep_tab   [num_tests] = '{4'hF, 4'hF, 4'hF, 4'h1, 4'h3,
                                                      4'h7, 4'hF, 4'hF, 4'hF};
    localparam logic [15:0] pre_tab   [num_tests] = '{16'd4, 16'd4, 16'd4, 16'd4, 16'd4,
                                                      16'd1, 16'd12, 16'd1, 16'd60};
    localparam logic [7:0] stall_tab  [num_tests] = '{8'h00, 8'h00, 8'h00, 8'h00, 8'h24,
                                                      8'h00, 8'h55, 8'h81, 8'h00};
    localparam logic       expect_tab [num_tests] = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b1,
                                                      1'b1, 1'b1, 1'b1, 1'b1};

    logic                   axis_clk;
    logic                   axis_reset;
    axis_word_t             in_data;
    axis_keep_t             in_keep;
    logic                   in_last;
    logic                   in_user;
    logic                   in_valid;
    logic                   in_ready;
    logic [count_width-1:0] preamble_words;
    axis_word_t             preamble_pattern;
    axis_word_t             trailer_pattern;
    axis_word_t             out_data;
    axis_keep_t             out_keep;
    logic                   out_last;
    logic                   out_user;
    logic                   out_valid;

    int          test_idx;
    int          test_len;
    logic        test_expect;
    logic        test_start;
    logic        test_done;
    int          error_count;
    int          pass_count;
    int          fail_count;
    int          seed;
    logic [31:0] rnd;

    tb_clock #(.period_ns(clk_period)) clock_gen (
        .axis_clk   (axis_clk),
        .axis_reset (axis_reset)
    );

    xgpon_burst_tx dut (
        .axis_clk         (axis_clk),
        .axis_reset       (axis_reset),
        .in_data          (in_data),
        .in_keep          (in_keep),
        .in_last          (in_last),
        .in_user          (in_user),
        .in_valid         (in_valid),
        .in_ready         (in_ready),
        .preamble_words   (preamble_words),
        .preamble_pattern (preamble_pattern),
        .trailer_pattern  (trailer_pattern),
        .out_data         (out_data),
        .out_keep         (out_keep),
        .out_last         (out_last),
        .out_user         (out_user),
        .out_valid        (out_valid)
    );

    burst_checker burst_check (
        .axis_clk         (axis_clk),
        .axis_reset       (axis_reset),
        .in_data          (in_data),
        .in_keep          (in_keep),
        .in_last          (in_last),
        .in_user          (in_user),
        .in_valid         (in_valid),
        .in_ready         (in_ready),
        .preamble_words   (preamble_words),
        .preamble_pattern (preamble_pattern),
        .trailer_pattern  (trailer_pattern),
        .test_idx         (test_idx),
        .test_len         (test_len),
        .test_expect      (test_expect),
        .test_start       (test_start),
        .out_data         (out_data),
        .out_keep         (out_keep),
        .out_last         (out_last),
        .out_user         (out_user),
        .out_valid        (out_valid),
        .test_done        (test_done),
        .error_count      (error_count),
        .pass_count       (pass_count),
        .fail_count       (fail_count)
    );

    bind burst_sequencer burst_properties props (
        .axis_clk   (axis_clk),
        .axis_reset (axis_reset),
        .out_valid  (out_valid),
        .out_last   (out_last),
        .pop        (pop)
    );

    // worst case, every frame at half rate plus its framing and gap
    function automatic int watchdog_cycles();
        int total;
        total = 60;  // reset, idle row and closing wait
        for (int t = 0; t < num_tests; t++)
            total += 2 * len_tab[t] + int'(pre_tab[t]) + 1 + int'(trailer_repeat)
                   + int'(ifg_words) + 30;
        return total;
    endfunction

    // one frame, each word held until in_ready takes it
    task automatic send_frame(int t);
        int   sent;
        int   cyc;
        logic took;
        sent = 0;
        cyc  = 0;
        while (sent < len_tab[t]) begin
            if (!in_valid && !stall_tab[t][cyc % 8]) begin
                rnd      = $random(seed);
                in_data  = rnd;
                rnd      = $random(seed);
                in_user  = rnd[0];
                in_last  = (sent == len_tab[t] - 1);
                in_keep  = in_last ? keep_tab[t] : keep_all;
                in_valid = 1'b1;
            end
            took = in_valid && in_ready;  // in_ready only moves on the clock
            @(posedge axis_clk);
            #2;
            cyc++;
            if (took) begin
                sent++;
                in_valid = 1'b0;
            end
        end
        in_last = 1'b0;
    endtask

    task automatic run_test(int t);
        preamble_words = pre_tab[t];  // sequencer is idle or in its gap here
        test_idx       = t;
        test_len       = len_tab[t];
        test_expect    = expect_tab[t];
        test_start     = 1'b1;
        @(posedge axis_clk);
        #2;
        test_start = 1'b0;
        send_frame(t);
        while (!test_done) begin
            @(posedge axis_clk);
            #2;
        end
    endtask

    initial begin
        seed             = 40;
        in_data          = '0;
        in_keep          = keep_none;
        in_last          = 1'b0;
        in_user          = 1'b0;
        in_valid         = 1'b0;
        preamble_words   = 16'd4;
        preamble_pattern = 32'h5555_5555;  // alternating ones for clock recovery
        trailer_pattern  = 32'h3C3C_A5A5;
        test_idx         = 0;
        test_len         = 0;
        test_expect      = 1'b0;
        test_start       = 1'b0;
        @(negedge axis_reset);
        @(posedge axis_clk);
        #2;
        for (int t = 0; t < num_tests; t++)
            run_test(t);
        repeat (int'(ifg_words) + 10) @(posedge axis_clk);  // last gap drains
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 num_tests, pass_count, fail_count, error_count);
        if (error_count == 0 && fail_count == 0 && pass_count == num_tests
            && dut.u_sequencer.props.assert_failures == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    initial begin
        #(watchdog_cycles() * clk_period);
        $display("watchdog expired before all bursts completed");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* buffer/packet_buffer.sv */
`timescale 1ns/1ns

module packet_buffer
    import axis_pkg::*;
    import burst_pkg::*;
(
    input  logic       axis_clk,
    input  logic       axis_reset,

    // write side, axi-stream slave
    input  axis_word_t in_data,
    input  axis_keep_t in_keep,
    input  logic       in_last,
    input  logic       in_user,
    input  logic       in_valid,
    output logic       in_ready,

    // read side, oldest word shown fall-through
    input  logic       pop,
    output axis_word_t head_data,
    output axis_keep_t head_keep,
    output logic       head_last,
    output logic       head_user,
    output logic       head_valid,

    output logic       burst_ready  // enough stored to start a burst
);

    ////////////////////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////////////////////

    axis_word_t mem_data [buffer_depth];
    axis_keep_t mem_keep [buffer_depth];
    logic       mem_last [buffer_depth];
    logic       mem_user [buffer_depth];

    logic [addr_width-1:0]  wr_ptr;
    logic [addr_width-1:0]  rd_ptr;
    logic [count_width-1:0] word_count;  // words held
    logic [count_width-1:0] last_count;  // complete frames held

    logic do_write;
    logic do_read;

    assign in_ready = (word_count < buffer_depth);  // any free slot
    assign do_write = in_valid && in_ready;
    assign do_read  = pop && head_valid;

    always_ff @(posedge axis_clk) begin
        if (do_write) begin
            mem_data[wr_ptr] <= in_data;
            mem_keep[wr_ptr] <= in_keep;
            mem_last[wr_ptr] <= in_last;
            mem_user[wr_ptr] <= in_user;
        end
    end

    // async read, a write shows up at the head one cycle later
    assign head_valid = (word_count != '0);
    assign head_data  = mem_data[rd_ptr];
    assign head_keep  = mem_keep[rd_ptr];
    assign head_last  = mem_last[rd_ptr];
    assign head_user  = mem_user[rd_ptr];

    ////////////////////////////////////////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge axis_clk) begin
        if (axis_reset) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            word_count  <= '0;
            last_count  <= '0;
            burst_ready <= 1'b0;
        end else begin
            if (do_write)
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth, power of two
            if (do_read)
                rd_ptr <= rd_ptr + 1'b1;

            // net change, write and read may share a cycle
            word_count <= word_count + count_width'(do_write) - count_width'(do_read);

            // frames fully inside the buffer
            last_count <= last_count
                        + count_width'(do_write && in_last)
                        - count_width'(do_read && head_last);

            // lags the counts by one cycle
            burst_ready <= (word_count >= start_level) || (last_count != '0);
        end
    end

endmodule

/* common/axis_pkg.sv */
package axis_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // stream word geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int data_width = 32;                     // bits per stream word
    localparam int keep_width = 4;                      // one flag per byte
    localparam int byte_width = data_width / keep_width; // 8 bits per lane

    ////////////////////////////////////////////////////////////////////////////
    // word and mask types
    ////////////////////////////////////////////////////////////////////////////

    // payload word, byte 0 in the low bits
    typedef logic [data_width-1:0] axis_word_t;

    // byte valid mask, bit i covers byte i
    typedef logic [keep_width-1:0] axis_keep_t;

    // mask values used on framing and idle words
    localparam axis_keep_t keep_all  = '1;  // every byte valid
    localparam axis_keep_t keep_none = '0;  // nothing valid, gap and idle

endpackage

/* common/burst_pkg.sv */
package burst_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // counter widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int count_width = 16;  // occupancy and burst counters

    ////////////////////////////////////////////////////////////////////////////
    // burst framing
    ////////////////////////////////////////////////////////////////////////////

    // psync style delimiter, marks start of payload
    localparam logic [31:0] delimiter_word = 32'hB2C50FA1;

    localparam logic [count_width-1:0] trailer_repeat = 16'd3;   // trailer words
    localparam logic [count_width-1:0] ifg_words      = 16'd10;  // idle after burst

    // packet memory
    localparam logic [count_width-1:0] buffer_depth = 16'd64;    // words
    localparam logic [count_width-1:0] start_level  = 16'd10;    // early start level
    localparam int addr_width = $clog2(buffer_depth);            // pointer bits

    // sequencer states, in burst order
    typedef enum logic [2:0] {
        idle,       // waiting for burst_ready
        preamble,   // preamble words going out
        delimiter,  // delimiter on the lane, first pop
        data,       // frame payload
        trailer,    // trailer pattern repeats
        gap         // inter-frame idle
    } burst_state_t;

endpackage

/* framer/burst_sequencer.sv */
`timescale 1ns/1ns

module burst_sequencer
    import axis_pkg::*;
    import burst_pkg::*;
(
    input  logic                   axis_clk,
    input  logic                   axis_reset,

    // run configuration, steady while running
    input  logic [count_width-1:0] preamble_words,   // at least 1
    input  axis_word_t             preamble_pattern,
    input  axis_word_t             trailer_pattern,

    // buffer head
    input  axis_word_t             head_data,
    input  axis_keep_t             head_keep,
    input  logic                   head_last,
    input  logic                   head_user,
    input  logic                   head_valid,
    input  logic                   burst_ready,
    output logic                   pop,

    // raw lane side, never stalls
    output axis_word_t             out_data,
    output axis_keep_t             out_keep,
    output logic                   out_last,
    output logic                   out_user,
    output logic                   out_valid
);

    burst_state_t           state;
    logic [count_width-1:0] word_cnt;   // per-state word counter
    axis_word_t             data_word;  // head word after keep masking

    // pop while the delimiter or payload is on the lane
    assign pop = head_valid && ((state == delimiter) || (state == data));

    ////////////////////////////////////////////////////////////////////////////
    // last word byte masking
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        data_word = head_data;
        if (head_last) begin
            for (int i = 0; i < keep_width; i++) begin
                if (!head_keep[i])
                    data_word[i*byte_width +: byte_width] = '0;  // dead byte
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // burst FSM, outputs registered with the state
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge axis_clk) begin
        if (axis_reset) begin
            state     <= idle;
            word_cnt  <= '0;
            out_data  <= '0;
            out_keep  <= keep_none;
            out_last  <= 1'b0;
            out_user  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            // idle word unless a state says otherwise
            out_data  <= '0;
            out_keep  <= keep_none;
            out_last  <= 1'b0;
            out_user  <= 1'b0;
            out_valid <= 1'b0;

            case (state)
                idle: begin
                    if (burst_ready) begin
                        out_data  <= preamble_pattern;  // first preamble word
                        out_keep  <= keep_all;
                        out_valid <= 1'b1;
                        word_cnt  <= 16'd1;
                        state     <= preamble;
                    end
                end
                preamble: begin
                    out_keep  <= keep_all;
                    out_valid <= 1'b1;
                    if (word_cnt < preamble_words) begin
                        out_data <= preamble_pattern;
                        word_cnt <= word_cnt + 1'b1;
                    end else begin
                        out_data <= delimiter_word;  // preamble done
                        state    <= delimiter;
                    end
                end
                delimiter, data: begin
                    // a missing head word leaves a hole in the payload
                    if (head_valid) begin
                        out_data  <= data_word;
                        out_keep  <= head_keep;
                        out_user  <= head_user;
                        out_valid <= 1'b1;
                        if (head_last) begin
                            word_cnt <= '0;
                            state    <= trailer;
                        end else begin
                            state <= data;
                        end
                    end else begin
                        state <= data;
                    end
                end
                trailer: begin
                    out_data  <= trailer_pattern;
                    out_keep  <= keep_all;
                    out_valid <= 1'b1;
                    if (word_cnt == trailer_repeat - 1'b1) begin
                        out_last <= 1'b1;  // closes the burst
                        word_cnt <= '0;
                        state    <= gap;
                    end else begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end
                gap: begin
                    if (word_cnt == ifg_words - 1'b1) begin
                        word_cnt <= '0;
                        state    <= idle;
                    end else begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

/* hdl/xgpon_burst_tx.sv */
`timescale 1ns/1ns

module xgpon_burst_tx
    import axis_pkg::*;
    import burst_pkg::*;
(
    input  logic                   axis_clk,
    input  logic                   axis_reset,

    // ethernet frames in
    input  axis_word_t             in_data,
    input  axis_keep_t             in_keep,
    input  logic                   in_last,
    input  logic                   in_user,
    input  logic                   in_valid,
    output logic                   in_ready,

    // burst configuration
    input  logic [count_width-1:0] preamble_words,
    input  axis_word_t             preamble_pattern,
    input  axis_word_t             trailer_pattern,

    // framed bursts to the serial lane
    output axis_word_t             out_data,
    output axis_keep_t             out_keep,
    output logic                   out_last,
    output logic                   out_user,
    output logic                   out_valid
);

    ////////////////////////////////////////////////////////////////////////////
    // buffer head to sequencer
    ////////////////////////////////////////////////////////////////////////////

    axis_word_t head_data;
    axis_keep_t head_keep;
    logic       head_last;
    logic       head_user;
    logic       head_valid;
    logic       burst_ready;
    logic       pop;

    packet_buffer u_buffer (
        .axis_clk    (axis_clk),
        .axis_reset  (axis_reset),
        .in_data     (in_data),
        .in_keep     (in_keep),
        .in_last     (in_last),
        .in_user     (in_user),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .pop         (pop),
        .head_data   (head_data),
        .head_keep   (head_keep),
        .head_last   (head_last),
        .head_user   (head_user),
        .head_valid  (head_valid),
        .burst_ready (burst_ready)
    );

    burst_sequencer u_sequencer (
        .axis_clk         (axis_clk),
        .axis_reset       (axis_reset),
        .preamble_words   (preamble_words),
        .preamble_pattern (preamble_pattern),
        .trailer_pattern  (trailer_pattern),
        .head_data        (head_data),
        .head_keep        (head_keep),
        .head_last        (head_last),
        .head_user        (head_user),
        .head_valid       (head_valid),
        .burst_ready      (burst_ready),
        .pop              (pop),
        .out_data         (out_data),
        .out_keep         (out_keep),
        .out_last         (out_last),
        .out_user         (out_user),
        .out_valid        (out_valid)
    );

endmodule

/* list.f */
common/axis_pkg.sv
common/burst_pkg.sv
buffer/packet_buffer.sv
framer/burst_sequencer.sv
hdl/xgpon_burst_tx.sv
bench/tb_clock.sv
bench/burst_properties.sv
bench/burst_checker.sv
bench/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the burst framer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_top -f list.f --Mdir obj_dir -o tb_top_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/tb_top_sim)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1
